// File: common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data and address width, fixed for rv64
    localparam int unsigned xlen = 64;

    // bus id width
    localparam int unsigned id_w = 4;

    // byte offset inside one 8-byte beat
    localparam int unsigned off_w = 3;

    // operation kind from execute
    // none means no memory access, result forwarded as is
    typedef enum logic [2:0] {
        kind_none = 3'd0,
        kind_lb   = 3'd1,
        kind_lh   = 3'd2,
        kind_lw   = 3'd3,
        kind_ld   = 3'd4,
        kind_lbu  = 3'd5,
        kind_lhu  = 3'd6,
        kind_lwu  = 3'd7
    } load_kind_t;

    // operation handed over by execute, 195 bits
    typedef struct packed {
        load_kind_t        kind;
        logic [xlen-1:0]   base;
        logic [xlen-1:0]   offset;
        // forwarded when kind is none
        logic [xlen-1:0]   ex_result;
    } mem_req_t;

    // read-address channel payload, 71 bits
    typedef struct packed {
        // aligned down to the beat
        logic [xlen-1:0]   addr;
        logic [id_w-1:0]   id;
        // log2 of the byte count
        logic [2:0]        size;
    } axi_ar_t;

    // read-data channel payload, 68 bits
    typedef struct packed {
        logic [xlen-1:0]   data;
        logic [id_w-1:0]   id;
    } axi_r_t;

endpackage

`default_nettype wire

// File: mem/load_align.sv
`default_nettype none

module load_align (
    input  lsu_pkg::load_kind_t           kind,
    input  logic [lsu_pkg::off_w-1:0]     byte_off,
    input  logic [lsu_pkg::xlen-1:0]      beat,
    output logic [lsu_pkg::xlen-1:0]      value
);

    // beat with the addressed byte moved down to lane 0
    logic [lsu_pkg::xlen-1:0] shifted;

    // byte offset times 8 gives the bit shift
    assign shifted = beat >> {byte_off, 3'b000};

    always_comb begin
        case (kind)
            // byte loads
            lsu_pkg::kind_lb: begin
                value = {{(lsu_pkg::xlen-8){shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::kind_lbu: begin
                value = {{(lsu_pkg::xlen-8){1'b0}}, shifted[7:0]};
            end
            // halfword loads
            lsu_pkg::kind_lh: begin
                value = {{(lsu_pkg::xlen-16){shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::kind_lhu: begin
                value = {{(lsu_pkg::xlen-16){1'b0}}, shifted[15:0]};
            end
            // word loads
            lsu_pkg::kind_lw: begin
                value = {{(lsu_pkg::xlen-32){shifted[31]}}, shifted[31:0]};
            end
            lsu_pkg::kind_lwu: begin
                value = {{(lsu_pkg::xlen-32){1'b0}}, shifted[31:0]};
            end
            // full doubleword, offset is 0 for an aligned ld
            lsu_pkg::kind_ld: begin
                value = shifted;
            end
            default: begin
                // no load, value is not selected upstream
                value = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: mem/mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  lsu_pkg::mem_req_t           req,
    output logic                        busy,
    output logic                        load_done,
    output logic [lsu_pkg::xlen-1:0]    wb_result,
    output logic                        rd_start,
    output lsu_pkg::axi_ar_t            rd_ar,
    input  logic                        ar_done,
    input  logic                        rd_done,
    input  logic [lsu_pkg::xlen-1:0]    rd_data
);

    // load sequencing states
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_request = 2'd1,
        st_wait    = 2'd2,
        st_finish  = 2'd3
    } state_t;

    state_t state;
    state_t state_nxt;

    // effective address from execute operands
    logic [lsu_pkg::xlen-1:0]   eff_addr;

    // registered load info
    lsu_pkg::load_kind_t        kind_q;
    logic [lsu_pkg::xlen-1:0]   addr_q;
    logic [lsu_pkg::off_w-1:0]  off_q;
    logic [2:0]                 size;

    // extended load value
    logic [lsu_pkg::xlen-1:0]   load_value;

    assign eff_addr = req.base + req.offset;

    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // any load kind starts a read
                if (req.kind != lsu_pkg::kind_none) begin
                    state_nxt = st_request;
                end
            end
            st_request: begin
                // address accepted by the bus
                if (ar_done) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                // our beat has been registered by the port
                if (rd_done) begin
                    state_nxt = st_finish;
                end
            end
            default: begin
                // finish lasts one cycle
                state_nxt = st_idle;
            end
        endcase
    end

    // kind is control, cleared once the load retires
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kind_q <= lsu_pkg::kind_none;
        end else if (state == st_idle && req.kind != lsu_pkg::kind_none) begin
            kind_q <= req.kind;
        end else if (state == st_finish) begin
            kind_q <= lsu_pkg::kind_none;
        end
    end

    // address and lane offset captured with the load
    always_ff @(posedge clk) begin
        if (state == st_idle && req.kind != lsu_pkg::kind_none) begin
            addr_q <= {eff_addr[lsu_pkg::xlen-1:lsu_pkg::off_w], {lsu_pkg::off_w{1'b0}}};
            off_q  <= eff_addr[lsu_pkg::off_w-1:0];
        end
    end

    // access size as log2 of bytes
    always_comb begin
        case (kind_q)
            lsu_pkg::kind_lh,
            lsu_pkg::kind_lhu: size = 3'd1;
            lsu_pkg::kind_lw,
            lsu_pkg::kind_lwu: size = 3'd2;
            lsu_pkg::kind_ld:  size = 3'd3;
            default:           size = 3'd0;
        endcase
    end

    // read request toward the port, id is filled in there
    always_comb begin
        rd_ar.addr = addr_q;
        rd_ar.id   = '0;
        rd_ar.size = size;
    end

    assign rd_start  = (state == st_request);
    assign busy      = (state == st_request) || (state == st_wait);
    assign load_done = (state == st_finish);

    load_align u_load_align (
        .kind     (kind_q),
        .byte_off (off_q),
        .beat     (rd_data),
        .value    (load_value)
    );

    // non-load results bypass with no clock
    assign wb_result = (kind_q != lsu_pkg::kind_none) ? load_value : req.ex_result;

endmodule

`default_nettype wire

// File: hw/axi_rd_port.sv
`default_nettype none

module axi_rd_port #(
    parameter logic [lsu_pkg::id_w-1:0] lsu_id = 4'd2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // from the memory stage
    input  logic                        rd_start,
    input  lsu_pkg::axi_ar_t            rd_ar,
    output logic                        ar_done,
    output logic                        rd_done,
    output logic [lsu_pkg::xlen-1:0]    rd_data,
    // read-address channel
    output logic                        ar_valid,
    output lsu_pkg::axi_ar_t            ar,
    input  logic                        ar_ready,
    // read-data channel
    input  logic                        r_valid,
    input  lsu_pkg::axi_r_t             r,
    output logic                        r_ready
);

    // address sent, reply not yet seen
    logic r_pend;

    // new request only when nothing is in flight
    logic issue;

    // beat accepted and tagged with our id
    logic r_match;

    assign issue   = rd_start && !ar_valid && !r_pend;
    assign r_match = r_valid && r_ready && (r.id == lsu_id);

    // handshake seen by the memory stage in the same cycle
    assign ar_done = ar_valid && ar_ready;

    // ready stays up for every beat while waiting
    // foreign ids are taken off the shared bus and dropped
    assign r_ready = r_pend;

    // address channel control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
        end else if (issue) begin
            ar_valid <= 1'b1;
        end else if (ar_done) begin
            ar_valid <= 1'b0;
        end
    end

    // payload held until ar_ready
    always_ff @(posedge clk) begin
        if (issue) begin
            ar.addr <= rd_ar.addr;
            ar.id   <= lsu_id;
            ar.size <= rd_ar.size;
        end
    end

    // reply tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_pend <= 1'b0;
        end else if (ar_done) begin
            r_pend <= 1'b1;
        end else if (r_match) begin
            r_pend <= 1'b0;
        end
    end

    // one-cycle pulse after the matching beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_done <= 1'b0;
        end else begin
            rd_done <= r_match;
        end
    end

    // beat kept until the next match
    always_ff @(posedge clk) begin
        if (r_match) begin
            rd_data <= r.data;
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
`default_nettype none

module lsu_top #(
    parameter logic [lsu_pkg::id_w-1:0] lsu_id = 4'd2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // execute and write-back side
    input  lsu_pkg::mem_req_t           req,
    output logic                        busy,
    output logic                        load_done,
    output logic [lsu_pkg::xlen-1:0]    wb_result,
    // read-address channel
    output logic                        ar_valid,
    output lsu_pkg::axi_ar_t            ar,
    input  logic                        ar_ready,
    // read-data channel
    input  logic                        r_valid,
    input  lsu_pkg::axi_r_t             r,
    output logic                        r_ready
);

    // memory stage to read port
    logic                       rd_start;
    lsu_pkg::axi_ar_t           rd_ar;
    logic                       ar_done;
    logic                       rd_done;
    logic [lsu_pkg::xlen-1:0]   rd_data;

    mem_stage u_mem_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .busy      (busy),
        .load_done (load_done),
        .wb_result (wb_result),
        .rd_start  (rd_start),
        .rd_ar     (rd_ar),
        .ar_done   (ar_done),
        .rd_done   (rd_done),
        .rd_data   (rd_data)
    );

    // bus id set here and passed down
    axi_rd_port #(
        .lsu_id (lsu_id)
    ) u_axi_rd_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_start (rd_start),
        .rd_ar    (rd_ar),
        .ar_done  (ar_done),
        .rd_done  (rd_done),
        .rd_data  (rd_data),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .r_ready  (r_ready)
    );

endmodule

`default_nettype wire

// File: dv/lsu_checker.sv
`default_nettype none

module lsu_checker #(
    parameter logic [lsu_pkg::id_w-1:0] lsu_id = 4'd2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // high while the stimulus presents real operations
    input  logic                        active,
    input  lsu_pkg::mem_req_t           req,
    input  logic                        busy,
    input  logic                        load_done,
    input  logic [lsu_pkg::xlen-1:0]    wb_result,
    input  logic                        ar_valid,
    input  lsu_pkg::axi_ar_t            ar,
    input  logic                        ar_ready,
    input  logic                        r_valid,
    input  lsu_pkg::axi_r_t             r,
    input  logic                        r_ready,
    input  logic [lsu_pkg::xlen-1:0]    mem [64],
    output int                          tests,
    output int                          errors,
    output int                          loads,
    output int                          foreign
);

    // where the model thinks the load is
    typedef enum logic [1:0] {
        m_idle,
        m_addr,
        m_data,
        m_done
    } phase_t;

    phase_t                     phase;
    logic                       reset_pending;
    logic                       ar_seen;
    int                         done_cnt;
    int                         err_mark;
    lsu_pkg::load_kind_t        cur_kind;
    logic [lsu_pkg::xlen-1:0]   eff;
    logic [lsu_pkg::xlen-1:0]   exp_addr;
    logic [2:0]                 exp_size;
    logic [lsu_pkg::xlen-1:0]   exp_value;

    // log2 of the access width in bytes
    function automatic logic [2:0] size_of(input lsu_pkg::load_kind_t kind);
        case (kind)
            lsu_pkg::kind_lh, lsu_pkg::kind_lhu: size_of = 3'd1;
            lsu_pkg::kind_lw, lsu_pkg::kind_lwu: size_of = 3'd2;
            lsu_pkg::kind_ld:                    size_of = 3'd3;
            default:                             size_of = 3'd0;
        endcase
    endfunction

    // reference value, byte by byte from the stored beat
    function automatic logic [lsu_pkg::xlen-1:0] expect_load(
        input lsu_pkg::load_kind_t          kind,
        input logic [lsu_pkg::xlen-1:0]     beat,
        input logic [lsu_pkg::off_w-1:0]    off
    );
        int nbytes;
        logic [lsu_pkg::xlen-1:0] v;
        nbytes = 1 << size_of(kind);
        v = '0;
        for (int b = 0; b < nbytes; b++) begin
            v[b*8 +: 8] = beat[(int'(off) + b) * 8 +: 8];
        end
        // signed kinds copy the top kept bit upward
        if (kind inside {lsu_pkg::kind_lb, lsu_pkg::kind_lh, lsu_pkg::kind_lw} &&
            v[nbytes*8-1]) begin
            for (int b = nbytes * 8; b < lsu_pkg::xlen; b++) begin
                v[b] = 1'b1;
            end
        end
        expect_load = v;
    endfunction

    task automatic compare(input string sig, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %0h got %0h", $time, sig, expected, actual);
            errors++;
        end
    endtask

    task automatic check_level(input string sig, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %0b got %0b", $time, sig, expected, actual);
            errors++;
        end
    endtask

    task automatic complain(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errors++;
    endtask

    task automatic close_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "PASS" : "FAIL");
    endtask

    // samples at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (!rst_n) begin
            phase         = m_idle;
            reset_pending = 1'b1;
            tests         = 0;
            errors        = 0;
            loads         = 0;
            foreign       = 0;
        end else if (reset_pending) begin
            // first edge out of reset
            err_mark = errors;
            check_level("ar_valid", 1'b0, ar_valid);
            check_level("r_ready", 1'b0, r_ready);
            check_level("busy", 1'b0, busy);
            check_level("load_done", 1'b0, load_done);
            close_test("reset");
            reset_pending = 1'b0;
        end else begin
            case (phase)
                m_idle: begin
                    err_mark = errors;
                    // also catches a second load_done pulse
                    check_level("load_done", 1'b0, load_done);
                    check_level("busy", 1'b0, busy);
                    check_level("ar_valid", 1'b0, ar_valid);
                    if (active && req.kind == lsu_pkg::kind_none) begin
                        // forwarded in the same cycle
                        compare("wb_result", req.ex_result, wb_result);
                        close_test("none");
                    end else if (active) begin
                        cur_kind  = req.kind;
                        eff       = req.base + req.offset;
                        exp_addr  = {eff[lsu_pkg::xlen-1:3], 3'b000};
                        exp_size  = size_of(req.kind);
                        exp_value = expect_load(req.kind, mem[eff[8:3]], eff[2:0]);
                        ar_seen   = 1'b0;
                        phase     = m_addr;
                    end
                end
                m_addr: begin
                    check_level("busy", 1'b1, busy);
                    check_level("load_done", 1'b0, load_done);
                    if (ar_valid) begin
                        // fixed expectation also proves the payload is held
                        compare("ar.addr", exp_addr, ar.addr);
                        compare("ar.id", 64'(lsu_id), 64'(ar.id));
                        compare("ar.size", 64'(exp_size), 64'(ar.size));
                        ar_seen = 1'b1;
                        if (ar_ready) begin
                            phase = m_data;
                        end
                    end else if (ar_seen) begin
                        complain("ar_valid dropped before ar_ready was seen");
                    end
                end
                m_data: begin
                    check_level("busy", 1'b1, busy);
                    check_level("load_done", 1'b0, load_done);
                    check_level("ar_valid", 1'b0, ar_valid);
                    check_level("r_ready", 1'b1, r_ready);
                    if (r_valid && r_ready && r.id == lsu_id) begin
                        done_cnt = 0;
                        phase    = m_done;
                    end else if (r_valid && r_ready) begin
                        // shared bus beat, must be dropped
                        foreign++;
                    end
                end
                default: begin
                    done_cnt++;
                    if (done_cnt == 1) begin
                        check_level("load_done", 1'b0, load_done);
                        check_level("busy", 1'b1, busy);
                    end else begin
                        if (!load_done) begin
                            complain("load_done missing two cycles after the matching beat");
                        end else begin
                            compare("wb_result", exp_value, wb_result);
                        end
                        check_level("busy", 1'b0, busy);
                        loads++;
                        close_test(cur_kind.name());
                        phase = m_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_lsu.sv
`default_nettype none

module tb_lsu;

    localparam int clk_period = 8;
    localparam int n_ops      = 400;
    // 20 cycles per operation covers the longest ready and reply delays
    localparam int watchdog_cycles = n_ops * 20 + 40;
    // not the default, so the id really travels down
    localparam logic [lsu_pkg::id_w-1:0] bus_id = 4'd6;

    logic                       clk;
    logic                       rst_n;
    logic                       active;
    lsu_pkg::mem_req_t          req;
    logic                       busy;
    logic                       load_done;
    logic [lsu_pkg::xlen-1:0]   wb_result;
    logic                       ar_valid;
    lsu_pkg::axi_ar_t           ar;
    logic                       ar_ready;
    logic                       r_valid;
    lsu_pkg::axi_r_t            r;
    logic                       r_ready;

    // memory behind the bus, indexed by addr[8:3]
    logic [lsu_pkg::xlen-1:0]   mem [64];
    integer                     seed;

    // responder state
    logic                       ar_armed;
    int unsigned                ar_wait;
    logic                       rsp_pending;
    logic                       rsp_foreign;
    int unsigned                rsp_wait;
    logic [5:0]                 rsp_idx;

    // stimulus scratch
    lsu_pkg::mem_req_t          op;
    logic [11:0]                imm;
    logic [lsu_pkg::xlen-1:0]   target;

    int                         tests;
    int                         errors;
    int                         loads;
    int                         foreign;

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic int unsigned pick(input int unsigned n);
        pick = $unsigned($random(seed)) % n;
    endfunction

    lsu_top #(
        .lsu_id (bus_id)
    ) u_lsu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .busy      (busy),
        .load_done (load_done),
        .wb_result (wb_result),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready)
    );

    lsu_checker #(
        .lsu_id (bus_id)
    ) u_lsu_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .active    (active),
        .req       (req),
        .busy      (busy),
        .load_done (load_done),
        .wb_result (wb_result),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .mem       (mem),
        .tests     (tests),
        .errors    (errors),
        .loads     (loads),
        .foreign   (foreign)
    );

    // memory responder, ready after 0 to 3 cycles, reply after 0 to 4
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_ready    <= 1'b0;
            ar_armed    <= 1'b0;
            ar_wait     <= 0;
            r_valid     <= 1'b0;
            rsp_pending <= 1'b0;
            rsp_foreign <= 1'b0;
            rsp_wait    <= 0;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_ready    <= 1'b0;
                ar_armed    <= 1'b0;
                rsp_pending <= 1'b1;
                rsp_idx     <= ar.addr[8:3];
                rsp_wait    <= pick(5);
                // some replies are preceded by another master's beat
                rsp_foreign <= (pick(3) == 0);
            end else if (ar_valid && !ar_armed) begin
                ar_armed <= 1'b1;
                ar_wait  <= pick(4);
            end else if (ar_armed && ar_wait == 0) begin
                ar_ready <= 1'b1;
            end else if (ar_armed) begin
                ar_wait <= ar_wait - 1;
            end
            if (r_valid) begin
                // beat leaves once taken
                if (r_ready) begin
                    r_valid <= 1'b0;
                end
            end else if (rsp_pending && rsp_wait != 0) begin
                rsp_wait <= rsp_wait - 1;
            end else if (rsp_pending && rsp_foreign) begin
                r_valid     <= 1'b1;
                r.id        <= bus_id ^ 4'(1 + pick(15));
                r.data      <= {$random(seed), $random(seed)};
                rsp_foreign <= 1'b0;
                rsp_wait    <= pick(3);
            end else if (rsp_pending) begin
                r_valid     <= 1'b1;
                r.id        <= bus_id;
                r.data      <= mem[rsp_idx];
                rsp_pending <= 1'b0;
            end
        end
    end

    initial begin
        seed     = 32'h91fc_3a0f;
        rst_n    = 1'b0;
        active   = 1'b0;
        req      = '0;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {$random(seed), $random(seed)};
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // checker looks at reset values on this edge
        @(posedge clk);
        for (int n = 0; n < n_ops; n++) begin
            op.kind = (pick(4) == 0) ? lsu_pkg::kind_none
                                     : lsu_pkg::load_kind_t'(3'(1 + pick(7)));
            target = {$random(seed), $random(seed)};
            // keep every load inside one beat
            case (op.kind)
                lsu_pkg::kind_lh, lsu_pkg::kind_lhu: target[0] = 1'b0;
                lsu_pkg::kind_lw, lsu_pkg::kind_lwu: target[1:0] = 2'b00;
                lsu_pkg::kind_ld:                    target[2:0] = 3'b000;
                default:                             target = target;
            endcase
            // 12-bit signed immediate like the isa offset
            imm          = 12'($random(seed));
            op.offset    = {{(lsu_pkg::xlen-12){imm[11]}}, imm};
            op.base      = target - op.offset;
            op.ex_result = {$random(seed), $random(seed)};
            req    <= op;
            active <= 1'b1;
            @(posedge clk);
            // a load is held until the edge that shows load_done
            if (op.kind != lsu_pkg::kind_none) begin
                while (!load_done) begin
                    @(posedge clk);
                end
            end
        end
        req    <= '0;
        active <= 1'b0;
        repeat (4) @(posedge clk);
        $display("tests %0d, loads %0d, foreign beats %0d, errors %0d",
                 tests, loads, foreign, errors);
        if (errors == 0 && tests == n_ops + 1) begin
            $display("Test OK");
        end else begin
            if (tests != n_ops + 1) begin
                $display("%0d tests completed where %0d were expected", tests, n_ops + 1);
            end
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_cycles * clk_period);
        $display("run did not finish within %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/lsu_pkg.sv
mem/load_align.sv
mem/mem_stage.sv
hw/axi_rd_port.sv
hw/lsu_top.sv
dv/lsu_checker.sv
dv/tb_lsu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_lsu
FILELIST  ?= list.f

SIM  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the output has the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
